// ==== i2c_cmd_pkg.sv ====
package i2c_cmd_pkg;

    // ========================================================================
    // Command codes seen on cmd_type and upload_source
    // ========================================================================
    typedef enum logic [7:0] {
        CMD_I2C_CONFIG = 8'h04,
        CMD_I2C_WRITE  = 8'h05,
        CMD_I2C_READ   = 8'h06
    } cmd_code_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PARSE_CONFIG,
        S_PARSE_WRITE,
        S_PARSE_READ,
        S_EXEC_WRITE,   // One access per buffered byte
        S_EXEC_READ,    // Fills the read buffer
        S_UPLOAD_DATA   // Block upload of the read buffer
    } handler_state_e;

    typedef enum logic [1:0] {UP_IDLE, UP_SEND, UP_WAIT} upload_state_e;

    // Read body is addr hi, addr lo, len hi, len lo
    localparam int READ_CMD_LENGTH    = 4;
    localparam int WRITE_HEADER_BYTES = 2;  // Register address ahead of data

endpackage

// ==== i2c_bus_pkg.sv ====
package i2c_bus_pkg;

    typedef enum logic [7:0] {
        SPD_50K  = 8'd0,
        SPD_100K = 8'd1,
        SPD_200K = 8'd2,
        SPD_400K = 8'd3
    } speed_code_e;

    // Quarter SCL period minus one, in 50 MHz cycles
    localparam logic [19:0] SCL_DIV_50K   = 20'd249;
    localparam logic [19:0] SCL_DIV_100K  = 20'd124;
    localparam logic [19:0] SCL_DIV_200K  = 20'd61;
    localparam logic [19:0] SCL_DIV_400K  = 20'd30;
    localparam logic [19:0] SCL_DIV_RESET = SCL_DIV_100K;

    // Each bit phase of the engine spans four SCL quarters
    typedef enum logic [3:0] {
        E_IDLE, E_START, E_SHIFT, E_ACK, E_RESTART,
        E_READ, E_MACK, E_STOP, E_RECOVER
    } engine_state_e;

endpackage

// ==== i2c_xfer_if.sv ====
`timescale 1ns/1ps

interface i2c_xfer_if;

    logic        wr_req;    // One-cycle request pulses
    logic        rd_req;
    logic [15:0] reg_addr;
    logic [7:0]  wr_data;
    logic [6:0]  dev_id;
    logic [19:0] scl_div;
    logic [7:0]  rd_data;
    logic        done;      // Access finished, one cycle
    logic        ack;       // All slave ack slots were low

    modport handler (
        output wr_req, rd_req, reg_addr, wr_data, dev_id, scl_div,
        input  rd_data, done, ack
    );

    modport engine (
        input  wr_req, rd_req, reg_addr, wr_data, dev_id, scl_div,
        output rd_data, done, ack
    );

endinterface

// ==== i2c_cmd_handler.sv ====
`timescale 1ns/1ps

module i2c_cmd_handler
    import i2c_cmd_pkg::*, i2c_bus_pkg::*;
#(
    parameter int WRITE_BUFFER_SIZE = 128,
    parameter int READ_BUFFER_SIZE  = 128
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  cmd_type,
    input  logic [15:0] cmd_length,
    input  logic [7:0]  cmd_data,
    input  logic [15:0] cmd_data_index,
    input  logic        cmd_start,
    input  logic        cmd_data_valid,
    input  logic        cmd_done,
    output logic        cmd_ready,
    output logic        upload_active,
    output logic        upload_req,
    output logic [7:0]  upload_data,
    output logic [7:0]  upload_source,
    output logic        upload_valid,
    input  logic        upload_ready,
    output logic        xfer_nack,
    i2c_xfer_if.handler xfer
);

    localparam int WB_AW = $clog2(WRITE_BUFFER_SIZE);
    localparam int RB_AW = $clog2(READ_BUFFER_SIZE);

    handler_state_e state;
    upload_state_e  upload_state;

    logic [6:0]  dev_id_q;
    logic [19:0] scl_div_q;
    logic [15:0] reg_addr_q;
    logic [15:0] data_len;
    logic [15:0] data_ptr;
    logic [7:0]  wr_data_q;
    logic        wr_req_q;
    logic        rd_req_q;
    logic        busy;           // Access outstanding in the engine
    logic [15:0] body_idx;       // Write body index past the register address
    logic [7:0]  write_buffer [WRITE_BUFFER_SIZE];
    logic [7:0]  read_buffer  [READ_BUFFER_SIZE];

    assign upload_active = (state == S_UPLOAD_DATA);
    assign body_idx      = cmd_data_index - 16'(WRITE_HEADER_BYTES);

    assign xfer.wr_req   = wr_req_q;
    assign xfer.rd_req   = rd_req_q;
    assign xfer.reg_addr = reg_addr_q;
    assign xfer.wr_data  = wr_data_q;
    assign xfer.dev_id   = dev_id_q;
    assign xfer.scl_div  = scl_div_q;

    always_ff @(posedge clk) begin
        if (state == S_PARSE_WRITE && cmd_data_valid &&
            cmd_data_index >= 16'(WRITE_HEADER_BYTES) && body_idx < WRITE_BUFFER_SIZE) begin
            write_buffer[body_idx[WB_AW-1:0]] <= cmd_data;
        end
        if (state == S_EXEC_READ && busy && xfer.done) begin
            read_buffer[data_ptr[RB_AW-1:0]] <= xfer.rd_data;
        end
    end

    // ========================================================================
    // Command FSM and upload FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            upload_state  <= UP_IDLE;
            cmd_ready     <= 1'b1;
            dev_id_q      <= 7'h00;
            scl_div_q     <= SCL_DIV_RESET;
            reg_addr_q    <= 16'h0000;
            data_len      <= 16'h0000;
            data_ptr      <= 16'h0000;
            wr_data_q     <= 8'h00;
            wr_req_q      <= 1'b0;
            rd_req_q      <= 1'b0;
            busy          <= 1'b0;
            xfer_nack     <= 1'b0;
            upload_req    <= 1'b0;
            upload_valid  <= 1'b0;
            upload_data   <= 8'h00;
            upload_source <= CMD_I2C_READ;
        end else begin
            wr_req_q     <= 1'b0;
            rd_req_q     <= 1'b0;
            upload_valid <= 1'b0;

            case (state)
                S_IDLE: begin
                    busy     <= 1'b0;
                    data_ptr <= 16'h0000;
                    if (cmd_start) begin
                        case (cmd_type)
                            CMD_I2C_CONFIG: begin
                                xfer_nack <= 1'b0;
                                state     <= S_PARSE_CONFIG;
                            end
                            CMD_I2C_WRITE: begin
                                if (cmd_length > WRITE_HEADER_BYTES &&
                                    cmd_length - WRITE_HEADER_BYTES <= WRITE_BUFFER_SIZE) begin
                                    xfer_nack <= 1'b0;
                                    cmd_ready <= 1'b0;
                                    state     <= S_PARSE_WRITE;
                                end
                            end
                            CMD_I2C_READ: begin
                                if (cmd_length == 16'(READ_CMD_LENGTH)) begin
                                    xfer_nack <= 1'b0;
                                    cmd_ready <= 1'b0;
                                    state     <= S_PARSE_READ;
                                end
                            end
                            default: ;  // Not ours
                        endcase
                    end
                end

                S_PARSE_CONFIG: begin
                    if (cmd_data_valid && cmd_data_index == 16'd0) dev_id_q <= cmd_data[6:0];
                    if (cmd_data_valid && cmd_data_index == 16'd1) begin
                        case (speed_code_e'(cmd_data))
                            SPD_50K:  scl_div_q <= SCL_DIV_50K;
                            SPD_100K: scl_div_q <= SCL_DIV_100K;
                            SPD_200K: scl_div_q <= SCL_DIV_200K;
                            SPD_400K: scl_div_q <= SCL_DIV_400K;
                            default:  ;  // Unknown code keeps current speed
                        endcase
                    end
                    if (cmd_done) state <= S_IDLE;
                end

                S_PARSE_WRITE, S_PARSE_READ: begin
                    if (cmd_data_valid) begin
                        case (cmd_data_index)
                            16'd0: reg_addr_q[15:8] <= cmd_data;
                            16'd1: reg_addr_q[7:0]  <= cmd_data;
                            16'd2: if (state == S_PARSE_READ) data_len[15:8] <= cmd_data;
                            16'd3: if (state == S_PARSE_READ) data_len[7:0]  <= cmd_data;
                            default: ;
                        endcase
                    end
                    if (cmd_done) begin
                        data_ptr <= 16'h0000;
                        if (state == S_PARSE_WRITE) begin
                            data_len <= cmd_length - 16'(WRITE_HEADER_BYTES);
                            state    <= S_EXEC_WRITE;
                        end else begin
                            state <= S_EXEC_READ;
                        end
                    end
                end

                S_EXEC_WRITE: begin
                    if (!busy) begin
                        if (data_ptr < data_len) begin
                            wr_data_q <= write_buffer[data_ptr[WB_AW-1:0]];
                            wr_req_q  <= 1'b1;
                            busy      <= 1'b1;
                        end else begin
                            cmd_ready <= 1'b1;
                            state     <= S_IDLE;
                        end
                    end else if (xfer.done) begin
                        if (!xfer.ack) xfer_nack <= 1'b1;
                        data_ptr   <= data_ptr + 16'd1;
                        reg_addr_q <= reg_addr_q + 16'd1;  // Auto-increment
                        busy       <= 1'b0;
                    end
                end

                S_EXEC_READ: begin
                    if (!busy) begin
                        if (data_ptr < data_len && data_ptr < READ_BUFFER_SIZE) begin
                            rd_req_q <= 1'b1;
                            busy     <= 1'b1;
                        end else begin
                            data_len <= data_ptr;  // Bytes actually buffered
                            data_ptr <= 16'h0000;
                            state    <= S_UPLOAD_DATA;
                        end
                    end else if (xfer.done) begin
                        if (!xfer.ack) xfer_nack <= 1'b1;
                        data_ptr   <= data_ptr + 16'd1;
                        reg_addr_q <= reg_addr_q + 16'd1;
                        busy       <= 1'b0;
                    end
                end

                S_UPLOAD_DATA: begin
                    if (data_ptr >= data_len) begin
                        cmd_ready <= 1'b1;
                        state     <= S_IDLE;
                    end
                end

                default: state <= S_IDLE;
            endcase

            // One valid pulse per buffered byte on the upload side
            case (upload_state)
                UP_IDLE: begin
                    if (state == S_UPLOAD_DATA && data_ptr < data_len && upload_ready) begin
                        upload_req    <= 1'b1;
                        upload_data   <= read_buffer[data_ptr[RB_AW-1:0]];
                        upload_source <= CMD_I2C_READ;
                        upload_valid  <= 1'b1;
                        upload_state  <= UP_SEND;
                    end
                end
                UP_SEND: begin
                    if (upload_ready) begin  // Hold the pointer under back-pressure
                        data_ptr     <= data_ptr + 16'd1;
                        upload_state <= UP_WAIT;
                    end
                end
                UP_WAIT: begin
                    upload_req   <= 1'b0;
                    upload_state <= UP_IDLE;
                end
                default: upload_state <= UP_IDLE;
            endcase
        end
    end

endmodule

// ==== i2c_byte_engine.sv ====
`timescale 1ns/1ps

module i2c_byte_engine
    import i2c_bus_pkg::*;
#(
    parameter int WRITE_RECOVERY_CYCLES = 249
) (
    input  logic       clk,
    input  logic       rst_n,
    i2c_xfer_if.engine xfer,
    output logic       i2c_scl,
    inout  wire        i2c_sda
);

    localparam int RW = $clog2(WRITE_RECOVERY_CYCLES + 1) + 1;

    engine_state_e state;

    logic [19:0]   qcnt;         // Cycles within one quarter
    logic [1:0]    q;            // Quarter of the current bit slot
    logic          tick;
    logic [RW-1:0] rcnt;
    logic [2:0]    bit_cnt;
    logic [1:0]    byte_sel;     // dev id, addr hi, addr lo, data or dev id read
    logic          is_read;
    logic          ack_ok;
    logic [7:0]    shreg;
    logic          done_q;
    logic          scl_pulse;
    logic          scl_nxt;
    logic          sda_low_nxt;
    logic          sda_oe;

    assign tick      = (qcnt == xfer.scl_div);
    assign scl_pulse = (q == 2'd1) || (q == 2'd2);  // SCL high in the middle quarters

    assign xfer.done    = done_q;
    assign xfer.ack     = ack_ok;
    assign xfer.rd_data = shreg;

    assign i2c_sda = sda_oe ? 1'b0 : 1'bz;  // Open drain

    function automatic logic [7:0] next_byte(input logic [1:0] sel);
        case (sel)
            2'd0:    next_byte = {xfer.dev_id, 1'b0};
            2'd1:    next_byte = xfer.reg_addr[15:8];
            2'd2:    next_byte = xfer.reg_addr[7:0];
            default: next_byte = is_read ? {xfer.dev_id, 1'b1} : xfer.wr_data;
        endcase
    endfunction

    // ========================================================================
    // Line levels per phase and quarter
    // ========================================================================
    always_comb begin
        scl_nxt     = 1'b1;
        sda_low_nxt = 1'b0;
        case (state)
            E_START: begin
                scl_nxt     = (q != 2'd3);
                sda_low_nxt = (q != 2'd0);  // SDA falls while SCL high
            end
            E_SHIFT: begin
                scl_nxt     = scl_pulse;
                sda_low_nxt = ~shreg[7];
            end
            E_ACK, E_READ, E_MACK: scl_nxt = scl_pulse;  // SDA released
            E_RESTART: begin
                scl_nxt     = scl_pulse;
                sda_low_nxt = q[1];
            end
            E_STOP: begin
                scl_nxt     = (q != 2'd0);
                sda_low_nxt = ~q[1];        // SDA rises while SCL high
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_scl <= 1'b1;
            sda_oe  <= 1'b0;
        end else begin
            i2c_scl <= scl_nxt;
            sda_oe  <= sda_low_nxt;
        end
    end

    // ========================================================================
    // Access sequencer
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= E_IDLE;
            qcnt     <= '0;
            q        <= 2'd0;
            rcnt     <= '0;
            bit_cnt  <= 3'd0;
            byte_sel <= 2'd0;
            is_read  <= 1'b0;
            ack_ok   <= 1'b1;
            shreg    <= 8'h00;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                E_IDLE: begin
                    qcnt <= '0;
                    q    <= 2'd0;
                    if (xfer.wr_req || xfer.rd_req) begin
                        is_read  <= xfer.rd_req;
                        ack_ok   <= 1'b1;
                        byte_sel <= 2'd0;
                        bit_cnt  <= 3'd7;
                        shreg    <= next_byte(2'd0);
                        state    <= E_START;
                    end
                end

                E_RECOVER: begin  // Slave write cycle time
                    if (rcnt == RW'(WRITE_RECOVERY_CYCLES - 1)) begin
                        done_q <= 1'b1;
                        state  <= E_IDLE;
                    end else begin
                        rcnt <= rcnt + 1'b1;
                    end
                end

                default: begin
                    if (!tick) begin
                        qcnt <= qcnt + 20'd1;
                    end else begin
                        qcnt <= '0;
                        q    <= q + 2'd1;
                        if (q == 2'd1) begin  // Sample in the middle of SCL high
                            if (state == E_ACK && i2c_sda) ack_ok <= 1'b0;
                            if (state == E_READ) shreg <= {shreg[6:0], i2c_sda};
                        end
                        if (q == 2'd3) begin
                            case (state)
                                E_START, E_RESTART: state <= E_SHIFT;
                                E_SHIFT: begin
                                    if (bit_cnt == 3'd0) begin
                                        state <= E_ACK;
                                    end else begin
                                        bit_cnt <= bit_cnt - 3'd1;
                                        shreg   <= {shreg[6:0], 1'b0};
                                    end
                                end
                                E_ACK: begin
                                    bit_cnt <= 3'd7;
                                    if (!is_read && byte_sel == 2'd3) begin
                                        state <= E_STOP;
                                    end else if (is_read && byte_sel == 2'd3) begin
                                        state <= E_READ;
                                    end else begin
                                        byte_sel <= byte_sel + 2'd1;
                                        shreg    <= next_byte(byte_sel + 2'd1);
                                        state    <= (is_read && byte_sel == 2'd2) ?
                                                    E_RESTART : E_SHIFT;
                                    end
                                end
                                E_READ: begin
                                    if (bit_cnt == 3'd0) state <= E_MACK;
                                    else bit_cnt <= bit_cnt - 3'd1;
                                end
                                E_MACK: state <= E_STOP;  // NACK ends the read
                                E_STOP: begin
                                    rcnt <= '0;
                                    if (is_read) begin
                                        done_q <= 1'b1;
                                        state  <= E_IDLE;
                                    end else begin
                                        state <= E_RECOVER;
                                    end
                                end
                                default: state <= E_IDLE;
                            endcase
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== i2c_bridge_top.sv ====
`timescale 1ns/1ps

module i2c_bridge_top #(
    parameter int WRITE_BUFFER_SIZE     = 128,
    parameter int READ_BUFFER_SIZE      = 128,
    parameter int WRITE_RECOVERY_CYCLES = 249
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  cmd_type,
    input  logic [15:0] cmd_length,
    input  logic [7:0]  cmd_data,
    input  logic [15:0] cmd_data_index,
    input  logic        cmd_start,
    input  logic        cmd_data_valid,
    input  logic        cmd_done,
    output logic        cmd_ready,
    output logic        upload_active,
    output logic        upload_req,
    output logic [7:0]  upload_data,
    output logic [7:0]  upload_source,
    output logic        upload_valid,
    input  logic        upload_ready,
    output logic        xfer_nack,
    output logic        i2c_scl,
    inout  wire         i2c_sda
);

    i2c_xfer_if xfer ();

    i2c_cmd_handler #(
        .WRITE_BUFFER_SIZE (WRITE_BUFFER_SIZE),
        .READ_BUFFER_SIZE  (READ_BUFFER_SIZE)
    ) handler0 (.*);

    i2c_byte_engine #(
        .WRITE_RECOVERY_CYCLES (WRITE_RECOVERY_CYCLES)
    ) engine0 (.*);

endmodule

// ==== tb_i2c_slave_model.sv ====
`timescale 1ns/1ps

module tb_i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  logic scl,
    inout  wire  sda
);

    logic [7:0]  mem [65536];
    logic [7:0]  sr;
    logic [15:0] ptr;
    logic        addressed;
    logic        rw;
    logic        sending;     // Slave drives data bytes to the master
    logic        master_nack;
    logic        drive_low;
    int          cnt;         // SCL rising edges within the current byte slot
    int          byte_num;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 8'(a) ^ {a[14:8], a[15]} ^ 8'h3c;  // Depends on all address bits
        end
        ptr = 16'h0000;
        bus_reset();
    end

    task automatic bus_reset();
        cnt       = 0;
        byte_num  = 0;
        addressed = 1'b0;
        rw        = 1'b0;
        sending   = 1'b0;
        drive_low = 1'b0;
    endtask

    task automatic load_byte();
        sr        = mem[ptr];
        ptr       = ptr + 16'd1;
        drive_low = ~sr[7];
    endtask

    task automatic take_byte();
        if (byte_num == 0) begin
            addressed = (sr[7:1] == DEV_ADDR);
            rw        = sr[0];
        end else if (addressed && !rw) begin
            if (byte_num == 1) ptr[15:8] = sr;
            else if (byte_num == 2) ptr[7:0] = sr;
            else begin
                mem[ptr] = sr;
                ptr      = ptr + 16'd1;
            end
        end
        byte_num++;
    endtask

    // Start and stop both restart the byte framing
    always @(negedge sda) if (scl === 1'b1) bus_reset();
    always @(posedge sda) if (scl === 1'b1) bus_reset();

    always @(posedge scl) begin
        cnt = cnt + 1;
        if (!sending) begin
            if (cnt <= 8) sr = {sr[6:0], sda};
            if (cnt == 8) take_byte();
        end else if (cnt == 9) begin
            master_nack = (sda !== 1'b0);
        end
    end

    always @(negedge scl) begin
        if (cnt == 8) begin
            drive_low = sending ? 1'b0 : addressed;  // Ack slot
        end else if (cnt == 9) begin
            cnt       = 0;
            drive_low = 1'b0;
            if (!sending && addressed && rw && byte_num == 1) begin
                sending     = 1'b1;
                master_nack = 1'b0;
                load_byte();
            end else if (sending && !master_nack) begin
                load_byte();
            end else if (sending) begin
                sending   = 1'b0;
                addressed = 1'b0;
            end
        end else if (sending && cnt >= 1 && cnt <= 7) begin
            drive_low = ~sr[7-cnt];
        end
    end

endmodule

// ==== tb_i2c_bridge.sv ====
`timescale 1ns/1ps

module tb_i2c_bridge
    import i2c_cmd_pkg::*, i2c_bus_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 400000;

    logic clk, rst_n, cmd_start, cmd_data_valid, cmd_done, upload_ready;
    logic [7:0]  cmd_type, cmd_data;
    logic [15:0] cmd_length, cmd_data_index;
    wire  cmd_ready, upload_active, upload_req, upload_valid, xfer_nack, i2c_scl;
    wire  [7:0] upload_data, upload_source;
    wire  i2c_sda;

    logic [7:0]  ref_mem [65536];     // Expected slave contents
    logic [7:0]  got_q [$];
    logic [7:0]  body [16];
    logic [7:0]  d [8];
    logic [8*16-1:0] name;
    logic [7:0]  typ, dev, spd;
    logic [15:0] addr, cnt, flen;
    logic [6:0]  cur_dev;
    logic [19:0] cur_div;
    logic        ready_prev, exp_nack, done_file;
    int          seed, fd, n, val_errs, proto_errs, scl_edges, high_cnt, last_high, edges0;
    logic [8*160-1:0] rest;

    i2c_bridge_top #(.WRITE_RECOVERY_CYCLES(249)) dut0 (.*);
    tb_i2c_slave_model #(.DEV_ADDR(7'h50)) slave0 (.scl(i2c_scl), .sda(i2c_sda));
    pullup (i2c_sda);

    always #20 clk = ~clk;

    always @(posedge clk) #5 upload_ready <= ($random(seed) & 1) != 0;

    // ========================================================================
    // Upload and SCL monitors
    // ========================================================================
    always @(posedge clk) begin
        if (rst_n && upload_valid) begin
            assert (ready_prev) else begin
                $display("upload_valid came without upload_ready in test %0s", name);
                proto_errs++;
            end
            assert (upload_req) else begin
                $display("upload_req was low during a valid pulse in test %0s", name);
                proto_errs++;
            end
            assert (upload_source == 8'h06) else begin
                $display("ERR %0s source expected 06 actual %h", name, upload_source);
                val_errs++;
            end
            got_q.push_back(upload_data);
        end
        ready_prev = upload_ready;
        if (i2c_scl === 1'b1) high_cnt++;
        else if (high_cnt != 0) begin
            last_high = high_cnt;  // Width of the latest SCL high pulse
            high_cnt  = 0;
        end
    end

    always @(negedge i2c_scl) scl_edges++;

    task automatic report_timeout(input string what);
        $display("Timeout waiting for %s in test %0s", what, name);
        $display("Errors: %0d value, %0d protocol, 1 timeout", val_errs, proto_errs);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic wait_level(input int which, input logic level, input string what);
        int t;
        t = 0;
        while (((which == 0) ? cmd_ready : upload_active) !== level) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT_CYCLES) report_timeout(what);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("ERR %0s %0s expected %h actual %h", name, what, exp, act);
            val_errs++;
        end
    endtask

    task automatic send_frame(input int nbytes);
        @(posedge clk);
        #5;
        cmd_start  = 1'b1;
        cmd_type   = typ;
        cmd_length = flen;
        @(posedge clk);
        #5;
        cmd_start = 1'b0;
        for (int i = 0; i < nbytes; i++) begin
            cmd_data_valid = 1'b1;
            cmd_data       = body[i];
            cmd_data_index = 16'(i);
            @(posedge clk);
            #5;
        end
        cmd_data_valid = 1'b0;
        cmd_done       = 1'b1;
        @(posedge clk);
        #5;
        cmd_done = 1'b0;
    endtask

    task automatic run_test();
        logic rejected;
        rejected = (typ == CMD_I2C_WRITE && (flen <= 2 || flen - 2 > 128)) ||
                   (typ == CMD_I2C_READ && flen != 16'(READ_CMD_LENGTH));
        wait_level(0, 1'b1, "cmd_ready");
        got_q.delete();
        edges0 = scl_edges;
        body[0] = addr[15:8];
        body[1] = addr[7:0];
        body[2] = (typ == CMD_I2C_READ) ? cnt[15:8] : d[0];
        body[3] = (typ == CMD_I2C_READ) ? cnt[7:0] : d[1];
        for (int i = 4; i < 10; i++) body[i] = d[i-2];
        if (typ == CMD_I2C_CONFIG) begin
            body[0] = dev;
            body[1] = spd;
            cur_dev = dev[6:0];
            case (speed_code_e'(spd))
                SPD_50K:  cur_div = SCL_DIV_50K;
                SPD_100K: cur_div = SCL_DIV_100K;
                SPD_200K: cur_div = SCL_DIV_200K;
                SPD_400K: cur_div = SCL_DIV_400K;
                default:  ;
            endcase
        end
        send_frame(flen);
        exp_nack = (cur_dev != 7'h50);
        if (typ == CMD_I2C_CONFIG) begin
            repeat (2) @(posedge clk);
        end else if (rejected) begin
            repeat (20) begin
                @(posedge clk);
                assert (cmd_ready) else begin
                    $display("cmd_ready dropped on a rejected command in %0s", name);
                    proto_errs++;
                end
            end
            check_value("scl edges", edges0, scl_edges);
            check_value("upload count", 0, got_q.size());
        end else begin
            if (typ == CMD_I2C_WRITE) begin
                wait_level(0, 1'b1, "end of write");
                if (!exp_nack) begin
                    for (int i = 0; i < cnt; i++) begin
                        ref_mem[addr+16'(i)] = d[i];
                    end
                end
                check_value("upload count", 0, got_q.size());
            end else begin
                wait_level(1, 1'b1, "upload_active rise");
                wait_level(1, 1'b0, "upload_active fall");
                @(posedge clk);
                check_value("upload count", cnt, got_q.size());
                check_value("upload_req", 0, upload_req);
                for (int i = 0; i < cnt && i < got_q.size(); i++) begin
                    check_value("data", exp_nack ? 8'hff : ref_mem[addr+16'(i)], got_q[i]);
                end
            end
            check_value("xfer_nack", exp_nack, xfer_nack);
            check_value("scl high cycles", 2 * (cur_div + 1), last_high);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        seed = 32'hf3d0_232d;
        clk = 1'b0;
        rst_n = 1'b0;
        upload_ready = 1'b1;
        ready_prev = 1'b1;
        cmd_start = 1'b0;
        cmd_data_valid = 1'b0;
        cmd_done = 1'b0;
        cmd_type = 8'h00;
        cmd_data = 8'h00;
        cmd_length = 16'h0;
        cmd_data_index = 16'h0;
        val_errs = 0;
        proto_errs = 0;
        scl_edges = 0;
        high_cnt = 0;
        last_high = 0;
        name = "reset";
        cur_dev = 7'h00;
        cur_div = SCL_DIV_RESET;
        for (int a = 0; a < 65536; a++) ref_mem[a] = 8'(a) ^ {a[14:8], a[15]} ^ 8'h3c;
        repeat (8) @(posedge clk);
        #5 rst_n = 1'b1;
        @(posedge clk);
        check_value("cmd_ready", 1, cmd_ready);
        check_value("upload_source", 8'h06, upload_source);
        check_value("upload_valid", 0, upload_valid);
        check_value("upload_req", 0, upload_req);
        check_value("upload_active", 0, upload_active);
        check_value("xfer_nack", 0, xfer_nack);
        check_value("scl", 1, i2c_scl);
        check_value("sda", 1, i2c_sda);
        fd = $fopen("i2c_bridge_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file");
            proto_errs++;
        end else begin
            done_file = 1'b0;
            while (!done_file) begin
                n = $fscanf(fd, "%s", name);
                if (n != 1) done_file = 1'b1;
                else if (name == "#") n = $fgets(rest, fd);  // Comment line
                else begin
                    n = $fscanf(fd, "%h %h %h %h %h %h", typ, dev, spd, addr, cnt, flen);
                    for (int i = 0; i < 8; i++) n = $fscanf(fd, "%h", d[i]);
                    run_test();
                end
            end
            $fclose(fd);
        end
        $display("Errors: %0d value, %0d protocol, 0 timeout", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== i2c_bridge_tests.txt ====
# columns: name type dev speed addr count frame_len d0 d1 d2 d3 d4 d5 d6 d7
# type 04 config, 05 write, 06 read; all values hex
cfg400   04 50 03 0000 0000 0002 00 00 00 00 00 00 00 00
wr4      05 00 00 0010 0004 0006 a1 b2 c3 d4 00 00 00 00
rd4      06 00 00 0010 0004 0004 00 00 00 00 00 00 00 00
rd3_inc  06 00 00 0011 0003 0004 00 00 00 00 00 00 00 00
wr1      05 00 00 0012 0001 0003 5e 00 00 00 00 00 00 00
rd3_back 06 00 00 0011 0003 0004 00 00 00 00 00 00 00 00
wr_bad   05 00 00 0020 0000 0002 00 00 00 00 00 00 00 00
rd_bad   06 00 00 0010 0003 0003 00 00 00 00 00 00 00 00
rd_after 06 00 00 0010 0004 0004 00 00 00 00 00 00 00 00
cfg_22   04 22 03 0000 0000 0002 00 00 00 00 00 00 00 00
rd_nack  06 00 00 0010 0002 0004 00 00 00 00 00 00 00 00
cfg_50   04 50 03 0000 0000 0002 00 00 00 00 00 00 00 00
rd_ok    06 00 00 0010 0002 0004 00 00 00 00 00 00 00 00
rd8_bp   06 00 00 0040 0008 0004 00 00 00 00 00 00 00 00
cfg100   04 50 01 0000 0000 0002 00 00 00 00 00 00 00 00
wr_slow  05 00 00 0080 0002 0004 12 34 00 00 00 00 00 00
rd_slow  06 00 00 0080 0002 0004 00 00 00 00 00 00 00 00

// ==== sources.f ====
i2c_cmd_pkg.sv
i2c_bus_pkg.sv
i2c_xfer_if.sv
i2c_cmd_handler.sv
i2c_byte_engine.sv
i2c_bridge_top.sv
tb_i2c_slave_model.sv
tb_i2c_bridge.sv
